// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  //////////////////////////////
  // Widths and constants
  //////////////////////////////
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [XLEN-1:0] INST_LENGTH = 32'd4;
  localparam logic [XLEN-1:0] RESET_PC    = 32'h8000_0000;

  // Major opcodes
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_BEQ   = 3'b000;
  localparam logic [2:0] F3_BNE   = 3'b001;
  localparam logic [2:0] F3_BLT   = 3'b100;
  localparam logic [2:0] F3_BGE   = 3'b101;
  localparam logic [2:0] F3_BLTU  = 3'b110;
  localparam logic [2:0] F3_BGEU  = 3'b111;
  localparam logic [2:0] F3_PRIV  = 3'b000;  // ECALL, MRET, JALR
  localparam logic [2:0] F3_CSRRW = 3'b001;

  localparam logic [11:0] F12_ECALL = 12'h000;
  localparam logic [11:0] F12_MRET  = 12'h302;

  //////////////////////////////
  // Types
  //////////////////////////////
  typedef enum logic [3:0] {
    NONE, BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR, MRET, ECALL, CSRRW
  } tran_op_e;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
  } ex_pkt_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] dnpc;   // Next PC as resolved in execute
  } trace_t;

endpackage

`default_nettype wire

// ==== common/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

  //////////////////////////////
  // Machine CSR addresses
  //////////////////////////////
  localparam int CSR_ADDR_W = 12;

  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC  = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC   = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE = 12'h342;

  // Exception codes
  localparam logic [rv_pkg::XLEN-1:0] CAUSE_ECALL_M = 32'd11;

  //////////////////////////////
  // Request from decode
  //////////////////////////////
  typedef struct packed {
    logic                    we;
    logic [CSR_ADDR_W-1:0]   addr;
    logic [rv_pkg::XLEN-1:0] wdata;
  } csr_req_t;

endpackage

`default_nettype wire

// ==== src/fetch_pc.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_pc (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  wire                     redirect_i,
  input  wire  [rv_pkg::XLEN-1:0] dnpc_i,
  output logic [rv_pkg::XLEN-1:0] pc_o
);

  logic [rv_pkg::XLEN-1:0] pc_next;

  // Redirect wins over the sequential step
  always_comb begin
    if (redirect_i) begin
      pc_next = dnpc_i;
    end else begin
      pc_next = pc_o + rv_pkg::INST_LENGTH;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_o <= rv_pkg::RESET_PC;
    end else begin
      pc_o <= pc_next;
    end
  end

endmodule

`default_nettype wire

// ==== src/pipe_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_reg #(
  parameter type T = logic
) (
  input  wire  clk_i,
  input  wire  arst_n_i,
  input  wire  flush_i,
  input  var T d_i,
  output T     q_o
);

  // All-zero payload is a bubble
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      q_o <= '0;
    end else if (flush_i) begin
      q_o <= '0;
    end else begin
      q_o <= d_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/tran_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module tran_decode (
  input  var rv_pkg::ex_pkt_t              pkt_i,
  input  wire  [rv_pkg::XLEN-1:0]          csr_rdata_i,
  input  wire  [rv_pkg::XLEN-1:0]          rs1_data_i,
  output rv_pkg::tran_op_e                 tran_op_o,
  output logic [rv_pkg::XLEN-1:0]          imm_o,
  output logic [rv_pkg::XLEN-1:0]          operand1_o,
  output logic [rv_pkg::REG_ADDR_W-1:0]    rs1_addr_o,
  output logic [rv_pkg::REG_ADDR_W-1:0]    rs2_addr_o,
  output logic [rv_pkg::REG_ADDR_W-1:0]    rd_addr_o,
  output logic                             rd_we_o,
  output logic [rv_pkg::XLEN-1:0]          rd_data_o,
  output csr_pkg::csr_req_t                csr_req_o,
  output logic [csr_pkg::CSR_ADDR_W-1:0]   csr_raddr_o,
  output logic                             trap_o
);

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [11:0]             funct12;
  logic [rv_pkg::XLEN-1:0] imm_b;
  logic [rv_pkg::XLEN-1:0] imm_j;
  logic [rv_pkg::XLEN-1:0] imm_i;
  logic [rv_pkg::XLEN-1:0] link;
  logic                    is_link;

  assign opcode  = pkt_i.inst[6:0];
  assign funct3  = pkt_i.inst[14:12];
  assign funct12 = pkt_i.inst[31:20];

  assign rs1_addr_o = pkt_i.inst[19:15];
  assign rs2_addr_o = pkt_i.inst[24:20];
  assign rd_addr_o  = pkt_i.inst[11:7];

  //////////////////////////////
  // Immediates
  //////////////////////////////
  assign imm_b = {{20{pkt_i.inst[31]}}, pkt_i.inst[7], pkt_i.inst[30:25],
                  pkt_i.inst[11:8], 1'b0};
  assign imm_j = {{12{pkt_i.inst[31]}}, pkt_i.inst[19:12], pkt_i.inst[20],
                  pkt_i.inst[30:21], 1'b0};
  assign imm_i = {{20{pkt_i.inst[31]}}, pkt_i.inst[31:20]};

  //////////////////////////////
  // Operation decode
  //////////////////////////////
  always_comb begin
    tran_op_o = rv_pkg::NONE;  // Everything else retires as a no-op
    if (pkt_i.valid) begin
      case (opcode)
        rv_pkg::OPC_BRANCH: begin
          case (funct3)
            rv_pkg::F3_BEQ:  tran_op_o = rv_pkg::BEQ;
            rv_pkg::F3_BNE:  tran_op_o = rv_pkg::BNE;
            rv_pkg::F3_BLT:  tran_op_o = rv_pkg::BLT;
            rv_pkg::F3_BGE:  tran_op_o = rv_pkg::BGE;
            rv_pkg::F3_BLTU: tran_op_o = rv_pkg::BLTU;
            rv_pkg::F3_BGEU: tran_op_o = rv_pkg::BGEU;
            default:         tran_op_o = rv_pkg::NONE;
          endcase
        end
        rv_pkg::OPC_JAL: tran_op_o = rv_pkg::JAL;
        rv_pkg::OPC_JALR: begin
          if (funct3 == rv_pkg::F3_PRIV) tran_op_o = rv_pkg::JALR;
        end
        rv_pkg::OPC_SYSTEM: begin
          if (funct3 == rv_pkg::F3_CSRRW) begin
            tran_op_o = rv_pkg::CSRRW;
          end else if (funct3 == rv_pkg::F3_PRIV && funct12 == rv_pkg::F12_ECALL) begin
            tran_op_o = rv_pkg::ECALL;
          end else if (funct3 == rv_pkg::F3_PRIV && funct12 == rv_pkg::F12_MRET) begin
            tran_op_o = rv_pkg::MRET;
          end
        end
        default: tran_op_o = rv_pkg::NONE;
      endcase
    end
  end

  always_comb begin
    case (tran_op_o)
      rv_pkg::JAL:  imm_o = imm_j;
      rv_pkg::JALR: imm_o = imm_i;
      rv_pkg::BEQ, rv_pkg::BNE, rv_pkg::BLT, rv_pkg::BGE, rv_pkg::BLTU, rv_pkg::BGEU:
        imm_o = imm_b;
      default:      imm_o = '0;
    endcase
  end

  // Trap entry and return take their target from the CSR file
  always_comb begin
    case (tran_op_o)
      rv_pkg::MRET:  csr_raddr_o = csr_pkg::CSR_MEPC;
      rv_pkg::ECALL: csr_raddr_o = csr_pkg::CSR_MTVEC;
      default:       csr_raddr_o = funct12;
    endcase
  end

  assign operand1_o = (tran_op_o == rv_pkg::MRET || tran_op_o == rv_pkg::ECALL) ?
                      csr_rdata_i : rs1_data_i;

  //////////////////////////////
  // Write-back and CSR request
  //////////////////////////////
  assign link    = pkt_i.pc + rv_pkg::INST_LENGTH;
  assign is_link = (tran_op_o == rv_pkg::JAL) || (tran_op_o == rv_pkg::JALR);

  assign rd_we_o   = (is_link || tran_op_o == rv_pkg::CSRRW) && (rd_addr_o != '0);
  assign rd_data_o = (tran_op_o == rv_pkg::CSRRW) ? csr_rdata_i : link;  // Old CSR value

  assign csr_req_o = '{we: (tran_op_o == rv_pkg::CSRRW), addr: funct12, wdata: rs1_data_i};
  assign trap_o    = (tran_op_o == rv_pkg::ECALL);

endmodule

`default_nettype wire

// ==== src/addr_transfer.sv ====
`timescale 1ns/10ps
`default_nettype none

module addr_transfer (
  input  wire  [rv_pkg::XLEN-1:0] pc_i,
  input  wire  [rv_pkg::XLEN-1:0] imm_i,
  input  wire  [rv_pkg::XLEN-1:0] operand1_i,
  input  wire  [rv_pkg::XLEN-1:0] operand2_i,
  input  var rv_pkg::tran_op_e    tran_op_i,
  output logic [rv_pkg::XLEN-1:0] dnpc_o
);

  logic                    cout;
  logic [rv_pkg::XLEN-1:0] diff;
  logic                    zf;
  logic                    sf;
  logic                    of_flag;
  logic                    cf;
  logic                    signed_lt;
  logic                    unsigned_lt;
  logic                    taken;
  logic [rv_pkg::XLEN-1:0] seq_pc;
  logic [rv_pkg::XLEN-1:0] rel_pc;
  logic [rv_pkg::XLEN-1:0] jalr_sum;

  //////////////////////////////
  // Compare by subtraction
  //////////////////////////////
  assign {cout, diff} = {1'b0, operand1_i} + {1'b0, ~operand2_i} + 33'd1;

  assign of_flag = (operand1_i[31] & ~operand2_i[31] & ~diff[31]) |
                   (~operand1_i[31] & operand2_i[31] & diff[31]);
  assign cf = ~cout;  // Borrow out
  assign sf = diff[31];
  assign zf = ~(|diff);

  assign signed_lt   = sf ^ of_flag;
  assign unsigned_lt = cf;

  always_comb begin
    case (tran_op_i)
      rv_pkg::BEQ:  taken = zf;
      rv_pkg::BNE:  taken = ~zf;
      rv_pkg::BLT:  taken = signed_lt;
      rv_pkg::BGE:  taken = ~signed_lt;
      rv_pkg::BLTU: taken = unsigned_lt;
      rv_pkg::BGEU: taken = ~unsigned_lt;
      rv_pkg::JAL, rv_pkg::JALR, rv_pkg::MRET, rv_pkg::ECALL:
        taken = 1'b1;
      default:      taken = 1'b0;
    endcase
  end

  //////////////////////////////
  // Target select
  //////////////////////////////
  assign seq_pc   = pc_i + rv_pkg::INST_LENGTH;
  assign rel_pc   = pc_i + imm_i;
  assign jalr_sum = operand1_i + imm_i;

  always_comb begin
    if (!taken) begin
      dnpc_o = seq_pc;
    end else begin
      case (tran_op_i)
        rv_pkg::JALR:  dnpc_o = {jalr_sum[rv_pkg::XLEN-1:1], 1'b0};
        rv_pkg::MRET,
        rv_pkg::ECALL: dnpc_o = operand1_i;  // mepc or mtvec
        default:       dnpc_o = rel_pc;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/csr_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_file (
  input  wire                              clk_i,
  input  wire                              arst_n_i,
  input  var csr_pkg::csr_req_t            req_i,
  input  wire                              trap_i,
  input  wire  [rv_pkg::XLEN-1:0]          trap_pc_i,
  input  wire  [csr_pkg::CSR_ADDR_W-1:0]   raddr_i,
  output logic [rv_pkg::XLEN-1:0]          rdata_o
);

  logic [rv_pkg::XLEN-1:0] mtvec;
  logic [rv_pkg::XLEN-1:0] mepc;
  logic [rv_pkg::XLEN-1:0] mcause;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtvec  <= '0;
      mepc   <= '0;
      mcause <= '0;
    end else if (trap_i) begin
      mepc   <= trap_pc_i;
      mcause <= csr_pkg::CAUSE_ECALL_M;
    end else if (req_i.we) begin
      case (req_i.addr)
        csr_pkg::CSR_MTVEC:  mtvec  <= req_i.wdata;
        csr_pkg::CSR_MEPC:   mepc   <= req_i.wdata;
        csr_pkg::CSR_MCAUSE: mcause <= req_i.wdata;
        default: ;  // Unknown CSR ignored
      endcase
    end
  end

  // Read the value before this cycle's write
  always_comb begin
    case (raddr_i)
      csr_pkg::CSR_MTVEC:  rdata_o = mtvec;
      csr_pkg::CSR_MEPC:   rdata_o = mepc;
      csr_pkg::CSR_MCAUSE: rdata_o = mcause;
      default:             rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/pc_unit_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_unit_top (
  input  wire                              clk_i,
  input  wire                              arst_n_i,
  input  wire  [31:0]                      inst_i,
  input  wire  [rv_pkg::XLEN-1:0]          rs1_data_i,
  input  wire  [rv_pkg::XLEN-1:0]          rs2_data_i,
  output logic [rv_pkg::XLEN-1:0]          inst_addr_o,
  output logic [rv_pkg::REG_ADDR_W-1:0]    rs1_addr_o,
  output logic [rv_pkg::REG_ADDR_W-1:0]    rs2_addr_o,
  output logic                             rd_we_o,
  output logic [rv_pkg::REG_ADDR_W-1:0]    rd_addr_o,
  output logic [rv_pkg::XLEN-1:0]          rd_data_o,
  output rv_pkg::trace_t                   trace_o
);

  rv_pkg::ex_pkt_t                fetch_pkt;
  rv_pkg::ex_pkt_t                ex_pkt;
  rv_pkg::tran_op_e               tran_op;
  csr_pkg::csr_req_t              csr_req;
  logic [csr_pkg::CSR_ADDR_W-1:0] csr_raddr;
  logic [rv_pkg::XLEN-1:0]        csr_rdata;
  logic [rv_pkg::XLEN-1:0]        imm;
  logic [rv_pkg::XLEN-1:0]        operand1;
  logic [rv_pkg::XLEN-1:0]        dnpc;
  logic                           trap;
  logic                           redirect;

  //////////////////////////////
  // Fetch
  //////////////////////////////
  fetch_pc u_fetch_pc (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .redirect_i (redirect),
    .dnpc_i     (dnpc),
    .pc_o       (inst_addr_o)
  );

  assign fetch_pkt = '{valid: 1'b1, pc: inst_addr_o, inst: inst_i};

  pipe_reg #(.T(rv_pkg::ex_pkt_t)) u_ex_reg (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (redirect),  // Wrong-path fetch becomes a bubble
    .d_i      (fetch_pkt),
    .q_o      (ex_pkt)
  );

  //////////////////////////////
  // Execute
  //////////////////////////////
  tran_decode u_decode (
    .pkt_i       (ex_pkt),
    .csr_rdata_i (csr_rdata),
    .rs1_data_i  (rs1_data_i),
    .tran_op_o   (tran_op),
    .imm_o       (imm),
    .operand1_o  (operand1),
    .rs1_addr_o  (rs1_addr_o),
    .rs2_addr_o  (rs2_addr_o),
    .rd_addr_o   (rd_addr_o),
    .rd_we_o     (rd_we_o),
    .rd_data_o   (rd_data_o),
    .csr_req_o   (csr_req),
    .csr_raddr_o (csr_raddr),
    .trap_o      (trap)
  );

  addr_transfer u_addr_transfer (
    .pc_i       (ex_pkt.pc),
    .imm_i      (imm),
    .operand1_i (operand1),
    .operand2_i (rs2_data_i),
    .tran_op_i  (tran_op),
    .dnpc_o     (dnpc)
  );

  csr_file u_csr_file (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (csr_req),
    .trap_i    (trap),
    .trap_pc_i (ex_pkt.pc),
    .raddr_i   (csr_raddr),
    .rdata_o   (csr_rdata)
  );

  // Fetch is off the resolved path
  assign redirect = ex_pkt.valid && (dnpc != inst_addr_o);

  assign trace_o = '{valid: ex_pkt.valid, pc: ex_pkt.pc, dnpc: dnpc};

endmodule

`default_nettype wire

// ==== sim/pc_unit_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_unit_chk (
  input wire        clk_i,
  input wire        arst_n_i,
  input wire        rd_we_i,
  input wire [4:0]  rd_addr_i,
  input wire [31:0] inst_addr_i,
  input wire        redirect_i,
  input wire        trace_valid_i
);

  int unsigned fail_count = 0;  // Failed assertions so far

  a_no_rd0_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rd_we_i |-> rd_addr_i != '0)
  else begin
    $error("write-back to x0");
    fail_count++;
  end

  a_fetch_aligned: assert property (@(posedge clk_i) inst_addr_i[1:0] == 2'b00)
  else begin
    $error("fetch address not word aligned");
    fail_count++;
  end

  // One bubble, then the target retires
  a_one_bubble: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    redirect_i |=> !trace_valid_i ##1 trace_valid_i)
  else begin
    $error("redirect not followed by exactly one bubble");
    fail_count++;
  end

endmodule

bind pc_unit_top pc_unit_chk chk0 (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .rd_we_i       (rd_we_o),
  .rd_addr_i     (rd_addr_o),
  .inst_addr_i   (inst_addr_o),
  .redirect_i    (redirect),
  .trace_valid_i (trace_o.valid)
);

`default_nettype wire

// ==== sim/tb_pc_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_pc_unit;

  localparam int SEED = 37852;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] inst;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] dnpc;
    logic        rd_we;
    logic [4:0]  rd;
    logic [31:0] rd_data;
  } row_t;

  logic           clk_i = 1'b0;
  logic           arst_n_i;
  logic [31:0]    inst_i;
  logic [31:0]    rs1_data_i;
  logic [31:0]    rs2_data_i;
  logic [31:0]    inst_addr_o;
  logic [4:0]     rs1_addr_o;
  logic [4:0]     rs2_addr_o;
  logic           rd_we_o;
  logic [4:0]     rd_addr_o;
  logic [31:0]    rd_data_o;
  rv_pkg::trace_t trace_o;

  row_t        rows[$];            // Execution order
  logic [31:0] imem[logic [31:0]];
  logic [31:0] next_addr;
  int          seed;
  int          cycles = 0;
  int          cycle_limit = 0;

  pc_unit_top dut0 (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .inst_i      (inst_i),
    .rs1_data_i  (rs1_data_i),
    .rs2_data_i  (rs2_data_i),
    .inst_addr_o (inst_addr_o),
    .rs1_addr_o  (rs1_addr_o),
    .rs2_addr_o  (rs2_addr_o),
    .rd_we_o     (rd_we_o),
    .rd_addr_o   (rd_addr_o),
    .rd_data_o   (rd_data_o),
    .trace_o     (trace_o)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      fail_stop("Timeout: the instruction table did not retire within the cycle limit");
    end
  end

  task automatic fail_stop(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "Run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      fail_stop("Stopping at the first mismatch");
    end
  endtask

  //////////////////////////////
  // Encoding and reference model
  //////////////////////////////
  function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [12:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] itype_word(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [11:0] imm);
    return {imm, 5'd1, f3, rd, opc};  // rs1 is x1
  endfunction

  function automatic logic branch_holds(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [2:0] pick_f3(input int k);
    case (k)
      0:       return 3'b000;
      1:       return 3'b001;
      2:       return 3'b100;
      3:       return 3'b101;
      4:       return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  // Unmapped words decode as OP-IMM tagged with their address
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (imem.exists(addr)) begin
      return imem[addr];
    end
    return {addr[31:7] ^ addr[24:0], 7'b0010011};
  endfunction

  task automatic add_row(input logic [31:0] inst, input logic [31:0] rs1,
                         input logic [31:0] rs2, input logic [31:0] dnpc, input logic we,
                         input logic [4:0] rd, input logic [31:0] rd_data);
    row_t r;
    r = '{addr: next_addr, inst: inst, rs1: rs1, rs2: rs2, dnpc: dnpc,
          rd_we: we, rd: rd, rd_data: rd_data};
    rows.push_back(r);
    imem[next_addr] = inst;
    next_addr = dnpc;
  endtask

  task automatic add_branch(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b,
                            input logic [12:0] off);
    logic [31:0] target;
    target = branch_holds(f3, a, b) ? next_addr + {{19{off[12]}}, off} : next_addr + 32'd4;
    add_row(branch_word(f3, off), a, b, target, 1'b0, 5'd0, '0);
  endtask

  //////////////////////////////
  // Stimulus table
  //////////////////////////////
  task automatic build_table();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] mtvec_m;
    logic [31:0] mepc_m;
    logic [31:0] trap_pc;
    logic [31:0] h1;
    logic [31:0] h2;
    next_addr = rv_pkg::RESET_PC;
    mtvec_m   = '0;
    h1        = 32'h8000_1000;
    h2        = 32'h8000_2000;
    add_row(itype_word(7'b0010011, 3'b000, 5'd3, 12'd5), '0, '0, next_addr + 32'd4,
            1'b0, 5'd0, '0);
    add_branch(3'b000, 32'd5, 32'd5, 13'd12);
    add_branch(3'b000, 32'd5, 32'd6, 13'd12);
    add_branch(3'b000, 32'd9, 32'd9, 13'd4);  // Taken onto the fall-through
    add_branch(3'b001, 32'd5, 32'd6, 13'd12);
    add_branch(3'b001, 32'd7, 32'd7, 13'd12);
    add_branch(3'b100, 32'h8000_0000, 32'd1, 13'd12);
    add_branch(3'b100, 32'h7fff_ffff, 32'h8000_0000, 13'd12);  // Difference overflows
    add_branch(3'b100, 32'h8000_0000, 32'h7fff_ffff, 13'd12);
    add_branch(3'b101, 32'h7fff_ffff, 32'hffff_ffff, 13'd12);
    add_branch(3'b101, 32'hffff_ffff, 32'hffff_ffff, 13'd12);
    add_branch(3'b101, 32'd1, 32'd2, 13'd12);
    add_branch(3'b110, 32'd1, 32'hffff_ffff, 13'd12);
    add_branch(3'b110, 32'hffff_ffff, 32'd1, 13'd12);
    add_branch(3'b110, 32'd3, 32'd3, 13'd12);
    add_branch(3'b111, 32'd0, 32'd0, 13'd12);
    add_branch(3'b111, 32'd0, 32'd1, 13'd12);
    add_branch(3'b111, 32'h8000_0000, 32'h7fff_ffff, 13'd12);
    for (int k = 0; k < 12; k++) begin
      a = $random(seed);
      b = (k % 3 == 0) ? a : $random(seed);
      add_branch(pick_f3($unsigned($random(seed)) % 6), a, b, 13'd8);
    end
    // Undefined branch funct3, EBREAK, LUI
    add_row(branch_word(3'b010, 13'd12), '0, '0, next_addr + 32'd4, 1'b0, 5'd0, '0);
    add_row(32'h0010_0073, '0, '0, next_addr + 32'd4, 1'b0, 5'd0, '0);
    add_row(32'h1234_5237, '0, '0, next_addr + 32'd4, 1'b0, 5'd0, '0);
    add_row(jal_word(5'd1, 21'd16), '0, '0, next_addr + 32'd16, 1'b1, 5'd1,
            next_addr + 32'd4);
    add_row(jal_word(5'd0, 21'd8), '0, '0, next_addr + 32'd8, 1'b0, 5'd0, '0);
    a = 32'h8000_0403;
    add_row(itype_word(7'b1100111, 3'b000, 5'd5, 12'hffe), a, '0, (a - 32'd2) & ~32'd1,
            1'b1, 5'd5, next_addr + 32'd4);
    a = 32'h8000_04f0;
    add_row(itype_word(7'b1100111, 3'b000, 5'd6, 12'h010), a, '0, (a + 32'h10) & ~32'd1,
            1'b1, 5'd6, next_addr + 32'd4);
    // Trap entry, return onto the ECALL, second trap with a new handler
    add_row(itype_word(7'b1110011, 3'b001, 5'd7, csr_pkg::CSR_MTVEC), h1, '0,
            next_addr + 32'd4, 1'b1, 5'd7, mtvec_m);
    mtvec_m = h1;
    trap_pc = next_addr;
    mepc_m  = trap_pc;
    add_row(32'h0000_0073, '0, '0, mtvec_m, 1'b0, 5'd0, '0);
    add_row(itype_word(7'b1110011, 3'b001, 5'd8, csr_pkg::CSR_MTVEC), h2, '0,
            next_addr + 32'd4, 1'b1, 5'd8, mtvec_m);
    mtvec_m = h2;
    add_row(32'h3020_0073, '0, '0, mepc_m, 1'b0, 5'd0, '0);
    add_row(32'h0000_0073, '0, '0, mtvec_m, 1'b0, 5'd0, '0);
    add_row(itype_word(7'b1110011, 3'b001, 5'd9, csr_pkg::CSR_MCAUSE), '0, '0,
            next_addr + 32'd4, 1'b1, 5'd9, 32'd11);
    add_row(itype_word(7'b1110011, 3'b001, 5'd10, csr_pkg::CSR_MEPC), trap_pc + 32'd4, '0,
            next_addr + 32'd4, 1'b1, 5'd10, mepc_m);
    mepc_m = trap_pc + 32'd4;
    add_row(32'h3020_0073, '0, '0, mepc_m, 1'b0, 5'd0, '0);
    add_row(itype_word(7'b0010011, 3'b000, 5'd3, 12'd1), '0, '0, next_addr + 32'd4,
            1'b0, 5'd0, '0);
    add_row(itype_word(7'b0010011, 3'b000, 5'd4, 12'd2), '0, '0, next_addr + 32'd4,
            1'b0, 5'd0, '0);
  endtask

  //////////////////////////////
  // Run
  //////////////////////////////
  initial begin : main
    row_t        cur;
    int          idx;
    logic        bubble;
    logic [31:0] next_pc;
    arst_n_i   = 1'b0;
    inst_i     = '0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    seed       = SEED;
    build_table();
    cycle_limit = 4 * rows.size() + 20;
    repeat (2) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    check("inst_addr_o", inst_addr_o, rv_pkg::RESET_PC);
    idx     = 0;
    bubble  = 1'b1;  // Reset bubble in the stage register
    next_pc = rv_pkg::RESET_PC;
    while (idx < rows.size()) begin
      cur        = rows[idx];
      inst_i     = fetch_word(inst_addr_o);
      rs1_data_i = cur.rs1;
      rs2_data_i = cur.rs2;
      #3;
      check("trace_o.valid", 32'(trace_o.valid), 32'(!bubble));
      if (bubble) begin
        check("rd_we_o", 32'(rd_we_o), 32'd0);
        check("inst_addr_o", inst_addr_o, next_pc);
        bubble = 1'b0;
      end else begin
        check("trace_o.pc", trace_o.pc, cur.addr);
        check("trace_o.dnpc", trace_o.dnpc, cur.dnpc);
        check("inst_addr_o", inst_addr_o, cur.addr + 32'd4);
        check("rd_we_o", 32'(rd_we_o), 32'(cur.rd_we));
        if (cur.rd_we) begin
          check("rd_addr_o", 32'(rd_addr_o), 32'(cur.rd));
          check("rd_data_o", rd_data_o, cur.rd_data);
        end
        // Table encoders put rs1 in x1 and rs2 in x2
        if (cur.inst[6:0] == 7'b1100011) begin
          check("rs1_addr_o", 32'(rs1_addr_o), 32'd1);
          check("rs2_addr_o", 32'(rs2_addr_o), 32'd2);
        end
        if (cur.inst[6:0] == 7'b1100111 ||
            (cur.inst[6:0] == 7'b1110011 && cur.inst[14:12] == 3'b001)) begin
          check("rs1_addr_o", 32'(rs1_addr_o), 32'd1);
        end
        bubble  = (cur.dnpc != cur.addr + 32'd4);  // Off the sequential path
        next_pc = cur.dnpc;
        idx++;
      end
      @(posedge clk_i);
      #1;
    end
    if (dut0.chk0.fail_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      fail_stop("An assertion in the bound checker failed");
    end
  end

endmodule

`default_nettype wire

// ==== all.f ====
common/rv_pkg.sv
common/csr_pkg.sv
src/fetch_pc.sv
src/pipe_reg.sv
src/tran_decode.sv
src/addr_transfer.sv
src/csr_file.sv
src/pc_unit_top.sv
sim/pc_unit_chk.sv
sim/tb_pc_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build tb_pc_unit with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_pc_unit -f all.f -o tb_pc_unit_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_pc_unit_sim > sim.log 2>&1
cat sim.log
grep -qx '\*\* PASS \*\*' sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }
